// File: rtl/tank_pkg.sv
package tank_pkg;

	// rgb 4|4|4 colours
	// player tank
	localparam logic [11:0] colour_blue = 12'h00F;
	// enemy tank
	localparam logic [11:0] colour_red = 12'hF00;
	// background and blanking
	localparam logic [11:0] colour_black = 12'h000;

	// grid geometry in pixels
	localparam int grid_pitch = 20;
	// screen offset of cell 0
	localparam int grid_x0 = 160;
	localparam int grid_y0 = 40;
	// open half-extents, bounds are strict
	localparam int body_half = 7;
	localparam int barrel_half = 3;

	// barrel heading
	localparam logic [1:0] dir_up = 2'd0;
	localparam logic [1:0] dir_down = 2'd1;
	localparam logic [1:0] dir_left = 2'd2;
	localparam logic [1:0] dir_right = 2'd3;

	// write word opcodes, bit 11 in both views
	localparam logic op_place = 1'b0;
	localparam logic op_style = 1'b1;

	// host write word, one 12-bit word with two decodes
	typedef union packed {
		// cell placement
		struct packed {
			logic       op;
			logic       spare;
			logic [4:0] x_cell;
			logic [4:0] y_cell;
		} place;
		// look and heading
		struct packed {
			logic       op;
			logic [6:0] spare;
			logic       alive;
			logic       player;
			logic [1:0] dir;
		} style;
	} tank_wr_word_u;

endpackage

// File: rtl/vga_timing.sv
`timescale 1ns/1ps

module vga_timing
	#(
	parameter int h_active = 640,
	parameter int h_front = 16,
	parameter int h_sync = 96,
	parameter int h_back = 48,
	parameter int v_active = 480,
	parameter int v_front = 10,
	parameter int v_sync = 2,
	parameter int v_back = 33
	)
	(
	input  logic        clk,
	input  logic        rst_n,
	output logic [10:0] pix_x,
	output logic [10:0] pix_y,
	output logic        active,
	output logic        hs_raw,
	output logic        vs_raw
	);

	// line and frame lengths
	localparam int h_total = h_active + h_front + h_sync + h_back;
	localparam int v_total = v_active + v_front + v_sync + v_back;
	// sync windows start inclusive and end exclusive
	localparam int h_sync_start = h_active + h_front;
	localparam int h_sync_end = h_sync_start + h_sync;
	localparam int v_sync_start = v_active + v_front;
	localparam int v_sync_end = v_sync_start + v_sync;

	logic [10:0] h_next;
	logic [10:0] v_next;

	// next counter position at one pixel per clock
	always_comb
	begin
		h_next = pix_x + 11'd1;
		v_next = pix_y;
		// end of line wraps x and steps y
		if (pix_x == 11'(h_total - 1))
		begin
			h_next = '0;
			if (pix_y == 11'(v_total - 1))
				v_next = '0;
			else
				v_next = pix_y + 11'd1;
		end
	end

	// flags are computed from the next position so they line up with pix_x/pix_y
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pix_x <= '0;
			pix_y <= '0;
			// (0,0) is inside the visible area and the syncs idle high
			active <= 1'b1;
			hs_raw <= 1'b1;
			vs_raw <= 1'b1;
		end
		else
		begin
			pix_x <= h_next;
			pix_y <= v_next;
			active <= (h_next < h_active) && (v_next < v_active);
			// active low sync pulses
			hs_raw <= !((h_next >= h_sync_start) && (h_next < h_sync_end));
			vs_raw <= !((v_next >= v_sync_start) && (v_next < v_sync_end));
		end
	end

	// counters stay inside the frame
	a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
		(pix_x < h_total) && (pix_y < v_total));

endmodule

// File: rtl/tank_regs.sv
`timescale 1ns/1ps

module tank_regs
	import tank_pkg::*;
	#(
	parameter int n_tanks = 4
	)
	(
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         wr_en,
	input  logic [$clog2(n_tanks)-1:0]   wr_addr,
	input  tank_wr_word_u                wr_data,
	output logic [n_tanks*5-1:0]         x_cell,
	output logic [n_tanks*5-1:0]         y_cell,
	output logic [n_tanks*2-1:0]         dir,
	output logic [n_tanks-1:0]           alive,
	output logic [n_tanks-1:0]           player
	);

	// one-hot tank select for the current strobe
	logic [n_tanks-1:0] sel;

	always_comb
	begin
		sel = '0;
		for (int i = 0; i < n_tanks; i++)
		begin
			if (wr_en && (int'(wr_addr) == i))
				sel[i] = 1'b1;
		end
	end

	// attribute file, one slice per tank
	// a write shows up on the outputs on the next cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			x_cell <= '0;
			y_cell <= '0;
			dir <= '0;
			// every tank starts dead, nothing drawn
			alive <= '0;
			player <= '0;
		end
		else
		begin
			for (int i = 0; i < n_tanks; i++)
			begin
				if (sel[i])
				begin
					// opcode picks the view, other view's fields untouched
					if (wr_data.place.op == op_place)
					begin
						x_cell[i*5 +: 5] <= wr_data.place.x_cell;
						y_cell[i*5 +: 5] <= wr_data.place.y_cell;
					end
					else
					begin
						alive[i] <= wr_data.style.alive;
						player[i] <= wr_data.style.player;
						dir[i*2 +: 2] <= wr_data.style.dir;
					end
				end
			end
		end
	end

	// host may only address existing tanks
	a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> (int'(wr_addr) < n_tanks));

endmodule

// File: rtl/tank_render.sv
`timescale 1ns/1ps

module tank_render
	import tank_pkg::*;
	(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [10:0] pix_x,
	input  logic [10:0] pix_y,
	input  logic [4:0]  x_cell,
	input  logic [4:0]  y_cell,
	input  logic [1:0]  dir,
	input  logic        alive,
	input  logic        player,
	output logic        hit,
	output logic [11:0] colour
	);

	// tank centre on screen
	logic [10:0] cx;
	logic [10:0] cy;
	// pixel offset from the centre, signed
	logic signed [11:0] dx;
	logic signed [11:0] dy;
	// strict band tests on each axis
	logic narrow_x;
	logic narrow_y;
	logic wide_x;
	logic wide_y;
	logic neg_x;
	logic pos_x;
	logic neg_y;
	logic pos_y;
	// shape parts for the current heading
	logic in_barrel;
	logic in_body;

	// cell to pixel, max 31*20+160 fits in 11 bits
	assign cx = 11'(x_cell * grid_pitch + grid_x0);
	assign cy = 11'(y_cell * grid_pitch + grid_y0);

	assign dx = $signed({1'b0, pix_x}) - $signed({1'b0, cx});
	assign dy = $signed({1'b0, pix_y}) - $signed({1'b0, cy});

	// barrel width band
	assign narrow_x = (dx > -barrel_half) && (dx < barrel_half);
	assign narrow_y = (dy > -barrel_half) && (dy < barrel_half);
	// body width band
	assign wide_x = (dx > -body_half) && (dx < body_half);
	assign wide_y = (dy > -body_half) && (dy < body_half);
	// half planes, centre row and column excluded
	assign neg_x = (dx > -body_half) && (dx < 0);
	assign pos_x = (dx > 0) && (dx < body_half);
	assign neg_y = (dy > -body_half) && (dy < 0);
	assign pos_y = (dy > 0) && (dy < body_half);

	// barrel points along dir, body fills the opposite half
	always_comb
	begin
		unique case (dir)
			dir_up:
			begin
				in_barrel = narrow_x && neg_y;
				in_body = wide_x && pos_y;
			end
			dir_down:
			begin
				in_barrel = narrow_x && pos_y;
				in_body = wide_x && neg_y;
			end
			dir_left:
			begin
				in_barrel = narrow_y && neg_x;
				in_body = wide_y && pos_x;
			end
			default:
			begin
				in_barrel = narrow_y && pos_x;
				in_body = wide_y && neg_x;
			end
		endcase
	end

	// hit one cycle after pix_x/pix_y
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			hit <= 1'b0;
		else
			hit <= alive && (in_barrel || in_body);
	end

	// player blue, enemies red, only looked at when hit is set
	always_ff @(posedge clk)
	begin
		colour <= player ? colour_blue : colour_red;
	end

endmodule

// File: rtl/pixel_mux.sv
`timescale 1ns/1ps

module pixel_mux
	import tank_pkg::*;
	#(
	parameter int n_tanks = 4
	)
	(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [n_tanks-1:0]    hit,
	input  logic [n_tanks*12-1:0] colour,
	input  logic                  active,
	input  logic                  hs_raw,
	input  logic                  vs_raw,
	output logic [11:0]           rgb,
	output logic                  hsync,
	output logic                  vsync,
	output logic                  de
	);

	// timing flags delayed to match the renderer stage
	logic active_d;
	logic hs_d;
	logic vs_d;
	// winning colour for this pixel
	logic [11:0] pick;

	// walk from the top index down so tank 0 wins overlaps
	always_comb
	begin
		pick = colour_black;
		for (int i = n_tanks - 1; i >= 0; i--)
		begin
			if (hit[i])
				pick = colour[i*12 +: 12];
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active_d <= 1'b0;
			hs_d <= 1'b1;
			vs_d <= 1'b1;
			rgb <= colour_black;
			hsync <= 1'b1;
			vsync <= 1'b1;
			de <= 1'b0;
		end
		else
		begin
			active_d <= active;
			hs_d <= hs_raw;
			vs_d <= vs_raw;
			// blank shapes that spill past the visible edge
			rgb <= active_d ? pick : colour_black;
			hsync <= hs_d;
			vsync <= vs_d;
			de <= active_d;
		end
	end

	// no colour leaks into blanking
	a_blank: assert property (@(posedge clk) disable iff (!rst_n)
		!de |-> (rgb == colour_black));

endmodule

// File: rtl/tank_display.sv
`timescale 1ns/1ps

module tank_display
	import tank_pkg::*;
	#(
	parameter int n_tanks = 4,
	parameter int h_active = 640,
	parameter int h_front = 16,
	parameter int h_sync = 96,
	parameter int h_back = 48,
	parameter int v_active = 480,
	parameter int v_front = 10,
	parameter int v_sync = 2,
	parameter int v_back = 33
	)
	(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       wr_en,
	input  logic [$clog2(n_tanks)-1:0] wr_addr,
	input  tank_wr_word_u              wr_data,
	output logic [11:0]                rgb,
	output logic                       hsync,
	output logic                       vsync,
	output logic                       de
	);

	// counter stage
	logic [10:0] pix_x;
	logic [10:0] pix_y;
	logic active;
	logic hs_raw;
	logic vs_raw;
	// per-tank attributes, packed by tank index
	logic [n_tanks*5-1:0] x_cell;
	logic [n_tanks*5-1:0] y_cell;
	logic [n_tanks*2-1:0] dir;
	logic [n_tanks-1:0] alive;
	logic [n_tanks-1:0] player;
	// renderer stage
	logic [n_tanks-1:0] hit;
	logic [n_tanks*12-1:0] colour;

	vga_timing #(
		.h_active(h_active),
		.h_front(h_front),
		.h_sync(h_sync),
		.h_back(h_back),
		.v_active(v_active),
		.v_front(v_front),
		.v_sync(v_sync),
		.v_back(v_back)
	) u_timing (
		.clk(clk),
		.rst_n(rst_n),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.active(active),
		.hs_raw(hs_raw),
		.vs_raw(vs_raw)
	);

	tank_regs #(
		.n_tanks(n_tanks)
	) u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.x_cell(x_cell),
		.y_cell(y_cell),
		.dir(dir),
		.alive(alive),
		.player(player)
	);

	// one renderer per tank, all share the pixel position
	for (genvar i = 0; i < n_tanks; i++)
	begin : g_render
		tank_render u_render (
			.clk(clk),
			.rst_n(rst_n),
			.pix_x(pix_x),
			.pix_y(pix_y),
			.x_cell(x_cell[i*5 +: 5]),
			.y_cell(y_cell[i*5 +: 5]),
			.dir(dir[i*2 +: 2]),
			.alive(alive[i]),
			.player(player[i]),
			.hit(hit[i]),
			.colour(colour[i*12 +: 12])
		);
	end

	// pixel reaches rgb two clocks after the counters
	pixel_mux #(
		.n_tanks(n_tanks)
	) u_mux (
		.clk(clk),
		.rst_n(rst_n),
		.hit(hit),
		.colour(colour),
		.active(active),
		.hs_raw(hs_raw),
		.vs_raw(vs_raw),
		.rgb(rgb),
		.hsync(hsync),
		.vsync(vsync),
		.de(de)
	);

endmodule

// File: dv/tank_checker.sv
`timescale 1ns/1ps

module tank_checker
	import tank_pkg::*;
	#(
	parameter int n_tanks = 4,
	parameter int h_active = 640,
	parameter int h_front = 16,
	parameter int h_sync = 96,
	parameter int h_back = 48,
	parameter int v_active = 480,
	parameter int v_front = 10,
	parameter int v_sync = 2,
	parameter int v_back = 33
	)
	(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       wr_en,
	input  logic [$clog2(n_tanks)-1:0] wr_addr,
	input  tank_wr_word_u              wr_data,
	input  logic [11:0]                rgb,
	input  logic                       hsync,
	input  logic                       vsync,
	input  logic                       de,
	output int                         rgb_errs,
	output int                         sync_errs,
	output int                         de_errs,
	output int                         checks,
	output int                         lit
	);

	localparam int h_total = h_active + h_front + h_sync + h_back;
	localparam int v_total = v_active + v_front + v_sync + v_back;

	// mirror of the host writes
	int m_x [n_tanks];
	int m_y [n_tanks];
	logic [1:0] m_dir [n_tanks];
	bit m_alive [n_tanks];
	bit m_player [n_tanks];
	// model counters
	int hx;
	int vy;
	// {rgb, hsync, vsync, de}, two clocks of latency
	logic [14:0] stage1;
	logic [14:0] stage2;

	// first tank in index order that covers (x, y)
	function automatic logic [11:0] tank_pixel(input int x, input int y);
		int ox;
		int oy;
		int fwd;
		int side;
		int across;
		for (int t = 0; t < n_tanks; t++)
		begin
			ox = x - (m_x[t] * grid_pitch + grid_x0);
			oy = y - (m_y[t] * grid_pitch + grid_y0);
			// rotate so fwd points along the barrel
			case (m_dir[t])
				dir_up:
				begin
					fwd = -oy;
					side = ox;
				end
				dir_down:
				begin
					fwd = oy;
					side = ox;
				end
				dir_left:
				begin
					fwd = -ox;
					side = oy;
				end
				default:
				begin
					fwd = ox;
					side = oy;
				end
			endcase
			across = (side < 0) ? -side : side;
			// barrel ahead of the centre line, body behind
			if (m_alive[t] && ((across < barrel_half && fwd > 0 && fwd < body_half)
				|| (across < body_half && fwd < 0 && fwd > -body_half)))
				return m_player[t] ? colour_blue : colour_red;
		end
		return colour_black;
	endfunction

	function automatic logic [14:0] predict(input int x, input int y);
		logic vis;
		logic hs;
		logic vs;
		vis = (x < h_active) && (y < v_active);
		// sync pulses are active low
		hs = !((x >= h_active + h_front) && (x < h_active + h_front + h_sync));
		vs = !((y >= v_active + v_front) && (y < v_active + v_front + v_sync));
		return {vis ? tank_pixel(x, y) : colour_black, hs, vs, vis};
	endfunction

	function automatic bit mismatch(input string name, input logic [11:0] exp,
		input logic [11:0] act);
		if (act === exp)
			return 1'b0;
		$display("FAIL %0t %s expected %0h got %0h", $time, name, exp, act);
		return 1'b1;
	endfunction

	// outputs and inputs are both settled at the falling edge
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			hx = 0;
			vy = 0;
			// black, syncs idle high, de low
			stage1 = {colour_black, 3'b110};
			stage2 = stage1;
			for (int t = 0; t < n_tanks; t++)
			begin
				m_x[t] = 0;
				m_y[t] = 0;
				m_dir[t] = dir_up;
				m_alive[t] = 1'b0;
				m_player[t] = 1'b0;
			end
		end
		else
		begin
			checks++;
			if (mismatch("rgb", stage2[14:3], rgb))
				rgb_errs++;
			if (mismatch("hsync", 12'(stage2[2]), 12'(hsync)))
				sync_errs++;
			if (mismatch("vsync", 12'(stage2[1]), 12'(vsync)))
				sync_errs++;
			if (mismatch("de", 12'(stage2[0]), 12'(de)))
				de_errs++;
			if (stage2[14:3] != colour_black)
				lit++;
			stage2 = stage1;
			stage1 = predict(hx, vy);
			// captured on the coming edge, so first seen by the next pixel
			if (wr_en)
			begin
				if (wr_data.style.op == op_style)
				begin
					m_alive[wr_addr] = wr_data.style.alive;
					m_player[wr_addr] = wr_data.style.player;
					m_dir[wr_addr] = wr_data.style.dir;
				end
				else
				begin
					m_x[wr_addr] = wr_data.place.x_cell;
					m_y[wr_addr] = wr_data.place.y_cell;
				end
			end
			hx++;
			if (hx == h_total)
			begin
				hx = 0;
				vy = (vy + 1) % v_total;
			end
		end
	end

endmodule

// File: dv/tb_tank_display.sv
`timescale 1ns/1ps

module tb_tank_display
	import tank_pkg::*;
	();

	localparam int n_tanks = 4;
	localparam int h_active = 640;
	localparam int h_front = 16;
	localparam int h_sync = 96;
	localparam int h_back = 48;
	localparam int v_active = 480;
	localparam int v_front = 10;
	localparam int v_sync = 2;
	localparam int v_back = 33;
	localparam int frame_cycles = (h_active + h_front + h_sync + h_back)
		* (v_active + v_front + v_sync + v_back);

	logic clk;
	logic rst_n;
	logic wr_en;
	logic [$clog2(n_tanks)-1:0] wr_addr;
	tank_wr_word_u wr_data;
	logic [11:0] rgb;
	logic hsync;
	logic vsync;
	logic de;
	// counts from the checker
	int rgb_errs;
	int sync_errs;
	int de_errs;
	int checks;
	int lit;
	int other_errs;
	// write table with one strobe per row
	int row_tank [$];
	tank_wr_word_u row_word [$];
	int row_frames [$];
	bit table_ready;

	tank_display #(
		.n_tanks(n_tanks),
		.h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
		.v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
	) uut (
		.clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rgb(rgb), .hsync(hsync), .vsync(vsync), .de(de)
	);

	tank_checker #(
		.n_tanks(n_tanks),
		.h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
		.v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
	) chk (
		.clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rgb(rgb), .hsync(hsync), .vsync(vsync), .de(de),
		.rgb_errs(rgb_errs), .sync_errs(sync_errs), .de_errs(de_errs),
		.checks(checks), .lit(lit)
	);

	// 10 ns pixel clock
	always #5 clk = ~clk;

	function automatic tank_wr_word_u place_word(input int x, input int y);
		tank_wr_word_u w;
		w = '0;
		w.place.op = op_place;
		w.place.x_cell = 5'(x);
		w.place.y_cell = 5'(y);
		return w;
	endfunction

	function automatic tank_wr_word_u style_word(input bit alive, input bit player,
		input logic [1:0] dir);
		tank_wr_word_u w;
		w = '0;
		w.style.op = op_style;
		w.style.alive = alive;
		w.style.player = player;
		w.style.dir = dir;
		return w;
	endfunction

	task automatic add_row(input int tank, input tank_wr_word_u word, input int frames);
		row_tank.push_back(tank);
		row_word.push_back(word);
		row_frames.push_back(frames);
	endtask

	// one strobe with inputs moved 1 ns after the edge
	task automatic write_row(input int r);
		@(posedge clk);
		#1;
		wr_en = 1'b1;
		wr_addr = row_tank[r];
		wr_data = row_word[r];
		@(posedge clk);
		#1;
		wr_en = 1'b0;
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		other_errs = 0;
		// seed the generator once
		void'($urandom(54));
		// player facing up
		add_row(0, place_word(5, 5), 0);
		add_row(0, style_word(1'b1, 1'b1, dir_up), 1);
		// the other three headings with red enemies
		add_row(0, style_word(1'b1, 1'b1, dir_down), 0);
		add_row(1, place_word(10, 3), 0);
		add_row(1, style_word(1'b1, 1'b0, dir_left), 0);
		add_row(2, place_word(15, 8), 0);
		add_row(2, style_word(1'b1, 1'b0, dir_right), 1);
		// kill tank 1 then move tank 2 keeping its style
		add_row(1, style_word(1'b0, 1'b0, dir_left), 0);
		add_row(2, place_word(2, 12), 1);
		// enemy right on top of the player so tank 0 wins
		add_row(3, place_word(5, 5), 0);
		add_row(3, style_word(1'b1, 1'b0, dir_up), 1);
		// shapes across the right and bottom edges
		add_row(1, place_word(24, 10), 0);
		add_row(1, style_word(1'b1, 1'b0, dir_left), 0);
		add_row(2, place_word(8, 22), 1);
		// random placements
		for (int i = 0; i < 2; i++)
			add_row($urandom % n_tanks, place_word($urandom % 32, $urandom % 32), i);
		table_ready = 1'b1;

		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// first frame shows an empty screen
		@(negedge vsync);
		// writes land in vertical blanking just after the sync pulse starts
		for (int r = 0; r < row_tank.size(); r++)
		begin
			write_row(r);
			repeat (row_frames[r]) @(negedge vsync);
		end

		if (checks == 0)
		begin
			$display("the checker compared no pixels");
			other_errs++;
		end
		if (lit == 0)
		begin
			$display("no tank pixel was expected anywhere in the run");
			other_errs++;
		end
		$display("errors: rgb %0d, sync %0d, de %0d, other %0d, over %0d pixels",
			rgb_errs, sync_errs, de_errs, other_errs, checks);
		if (rgb_errs + sync_errs + de_errs + other_errs == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// watchdog at twice the frames the table asks for
	initial
	begin
		longint limit_ns;
		wait (table_ready);
		// the leading empty frame
		limit_ns = 1;
		foreach (row_frames[r])
			limit_ns += row_frames[r];
		limit_ns = limit_ns * frame_cycles * 10 * 2;
		#(limit_ns);
		$display("timeout: the run did not finish within %0d ns", limit_ns);
		$display("sim failed");
		$finish;
	end

endmodule

// File: list.f
rtl/tank_pkg.sv
rtl/vga_timing.sv
rtl/tank_regs.sv
rtl/tank_render.sv
rtl/pixel_mux.sv
rtl/tank_display.sv
dv/tank_checker.sv
dv/tb_tank_display.sv

// File: Bender.yml
package:
  name: tank_display

sources:
  # design, package first
  - rtl/tank_pkg.sv
  - rtl/vga_timing.sv
  - rtl/tank_regs.sv
  - rtl/tank_render.sv
  - rtl/pixel_mux.sv
  - rtl/tank_display.sv

  # testbench
  - target: simulation
    files:
      - dv/tank_checker.sv
      - dv/tb_tank_display.sv
